// ==== Makefile ====
# Verilator build and run for the execute core testbench
VERILATOR ?= verilator
TOP ?= exec_core_tb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= Done: errors found
VFLAGS ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== alu.sv ====
// Shift amounts use only op_b[4:0] so widths above 32 cannot shift by their full range
module alu #(
	parameter int data_width = core_pkg::data_width_def
) (
	input logic [data_width-1:0] op_a,
	input logic [data_width-1:0] op_b,
	input ctrl_pkg::alu_funct_t funct,
	output logic [data_width-1:0] res,
	output core_pkg::flags_t flags_out
);
	import ctrl_pkg::*;

	localparam int msb = data_width - 1;

	logic [data_width:0] sum; // Extra top bit holds carry or borrow
	logic carry;
	logic ovf;

	// Adder path with carry and signed overflow
	always_comb begin
		sum = '0;
		carry = 1'b0;
		ovf = 1'b0;
		case (funct)
			alu_add: begin
				sum = {1'b0, op_a} + {1'b0, op_b};
				carry = sum[data_width];
				ovf = (op_a[msb] == op_b[msb]) && (sum[msb] != op_a[msb]);
			end
			alu_sub: begin
				sum = {1'b0, op_a} - {1'b0, op_b};
				carry = sum[data_width]; // Set on borrow
				ovf = (op_a[msb] != op_b[msb]) && (sum[msb] != op_a[msb]);
			end
			default: ;
		endcase
	end

	always_comb begin
		case (funct)
			alu_add: res = sum[msb:0];
			alu_sub: res = sum[msb:0];
			alu_and: res = op_a & op_b;
			alu_or: res = op_a | op_b;
			alu_xor: res = op_a ^ op_b;
			alu_slt: res = {{(data_width-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			alu_shl: res = op_a << op_b[4:0];
			alu_shr: res = op_a >> op_b[4:0]; // Logical
			default: res = '0;
		endcase
	end

	// Zero and negative come from the result for every function
	assign flags_out = {carry, ovf, res[msb], res == '0};

endmodule

// ==== core_pkg.sv ====
// Data-path sizes and shared data types; data_width must stay at least pc_width and at most 32 for the shifts
package core_pkg;

	// Default widths, overridden from the top level
	parameter int data_width_def = 32;
	parameter int pc_width_def = 16;

	// Register file
	parameter int reg_count = 16;
	typedef logic [3:0] reg_addr_t;
	parameter reg_addr_t link_reg = 4'd15; // jal destination

	// Instruction word layout, 32 bits fixed
	//   [31:26] opcode
	//   [25:22] rd, destination of R-type ops
	//   [21:18] rs, operand A and first compare operand
	//   [17:14] rt, operand B, second compare operand and addi destination
	//   [13:0]  immediate, sign-extended to data_width
	// beq and bne compare rs with rt
	// jal writes pc+1 to link_reg and jumps to pc+1 plus the immediate
	parameter int imm_width = 14;

	// ALU status, carry in the top bit
	typedef struct packed {
		logic carry;    // Carry out on add, borrow on sub
		logic overflow; // Signed overflow on add and sub
		logic negative; // Result MSB
		logic zero;     // Result all zero
	} flags_t;

endpackage

// ==== ctrl_pkg.sv ====
// Control encodings shared by the decoder, the ALU and the result stage; opcodes above op_jal are treated as nop
package ctrl_pkg;

	// Instruction opcodes, instr[31:26]
	typedef enum logic [5:0] {
		op_nop  = 6'd0,
		op_add  = 6'd1,  // rd = rs + rt
		op_sub  = 6'd2,  // rd = rs - rt
		op_and  = 6'd3,
		op_or   = 6'd4,
		op_xor  = 6'd5,
		op_slt  = 6'd6,  // Signed compare, result 0 or 1
		op_shl  = 6'd7,  // Shift by rt[4:0]
		op_shr  = 6'd8,  // Logical right shift
		op_addi = 6'd9,  // rt = rs + imm
		op_beq  = 6'd10,
		op_bne  = 6'd11,
		op_jal  = 6'd12
	} opcode_t;

	// ALU function select
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_slt = 3'd5,
		alu_shl = 3'd6,
		alu_shr = 3'd7
	} alu_funct_t;

	// Where the destination register index comes from
	typedef enum logic [1:0] {
		dst_rd   = 2'd0,
		dst_rt   = 2'd1,
		dst_link = 2'd2 // Fixed link register
	} dst_sel_t;

	// Writeback source
	typedef enum logic {
		wb_alu = 1'b0,
		wb_pc  = 1'b1 // pc+1, zero-extended
	} wb_sel_t;

endpackage

// ==== decode_stage.sv ====
// Register file resets to zero and r0 is an ordinary register; nop and unknown opcodes enter as bubbles
module decode_stage #(
	parameter int data_width = core_pkg::data_width_def,
	parameter int pc_width = core_pkg::pc_width_def
) (
	input logic clk,
	input logic rst,
	input logic [31:0] instr,
	input logic instr_valid,
	input logic [pc_width-1:0] pc,
	input logic branch_taken, // Squash from the result stage
	input logic wb_en,
	input core_pkg::reg_addr_t wb_addr,
	input logic [data_width-1:0] wb_data,
	output logic d_valid,
	output ctrl_pkg::alu_funct_t d_alu_funct,
	output logic d_use_imm,
	output core_pkg::reg_addr_t d_dst, // Resolved destination index
	output logic d_flag_write,
	output logic d_is_beq,
	output logic d_is_bne,
	output logic d_is_jal,
	output ctrl_pkg::wb_sel_t d_wb_sel,
	output logic [data_width-1:0] d_rs_data,
	output logic [data_width-1:0] d_rt_data,
	output logic [data_width-1:0] d_imm,
	output logic [pc_width-1:0] d_next_pc,
	output logic d_fwd_a, // Take operand A from the stage ahead
	output logic d_fwd_b
);
	import core_pkg::*;
	import ctrl_pkg::*;

	opcode_t opcode;
	reg_addr_t rd;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t dst;
	alu_funct_t funct;
	dst_sel_t dst_sel;
	wb_sel_t wb_sel;
	logic op_ok;
	logic use_imm;
	logic flag_write;
	logic is_beq;
	logic is_bne;
	logic is_jal;
	logic d_writes;
	logic fwd_a;
	logic fwd_b;
	logic [data_width-1:0] imm;
	logic [data_width-1:0] rs_data;
	logic [data_width-1:0] rt_data;
	logic [data_width-1:0] regs [reg_count];

	// Field split
	assign opcode = opcode_t'(instr[31:26]);
	assign rd = instr[25:22];
	assign rs = instr[21:18];
	assign rt = instr[17:14];
	assign imm = {{(data_width-imm_width){instr[imm_width-1]}}, instr[imm_width-1:0]};

	// Opcode to control fields
	always_comb begin
		op_ok = 1'b1;
		funct = alu_add;
		use_imm = 1'b0;
		dst_sel = dst_rd;
		flag_write = 1'b0;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_jal = 1'b0;
		wb_sel = wb_alu;
		case (opcode)
			op_add: flag_write = 1'b1;
			op_sub: begin
				funct = alu_sub;
				flag_write = 1'b1;
			end
			op_and: funct = alu_and;
			op_or: funct = alu_or;
			op_xor: funct = alu_xor;
			op_slt: begin
				funct = alu_slt;
				flag_write = 1'b1;
			end
			op_shl: funct = alu_shl;
			op_shr: funct = alu_shr;
			op_addi: begin
				use_imm = 1'b1;
				dst_sel = dst_rt;
				flag_write = 1'b1;
			end
			op_beq: begin
				funct = alu_sub; // Zero flag gives the compare
				flag_write = 1'b1;
				is_beq = 1'b1;
			end
			op_bne: begin
				funct = alu_sub;
				flag_write = 1'b1;
				is_bne = 1'b1;
			end
			op_jal: begin
				dst_sel = dst_link;
				is_jal = 1'b1;
				wb_sel = wb_pc;
			end
			op_nop: op_ok = 1'b0;
			default: op_ok = 1'b0; // Unused codes
		endcase
	end

	always_comb begin
		case (dst_sel)
			dst_rt: dst = rt;
			dst_link: dst = link_reg;
			default: dst = rd;
		endcase
	end

	// Reads see this cycle's writeback
	assign rs_data = (wb_en && wb_addr == rs) ? wb_data : regs[rs];
	assign rt_data = (wb_en && wb_addr == rt) ? wb_data : regs[rt];

	// Forward when the instruction moving into execute writes our source
	assign d_writes = d_valid && !d_is_beq && !d_is_bne;
	assign fwd_a = d_writes && (rs == d_dst);
	assign fwd_b = d_writes && (rt == d_dst);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// Control half of the decode/execute register
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			d_valid <= 1'b0;
			d_alu_funct <= alu_add;
			d_use_imm <= 1'b0;
			d_dst <= '0;
			d_flag_write <= 1'b0;
			d_is_beq <= 1'b0;
			d_is_bne <= 1'b0;
			d_is_jal <= 1'b0;
			d_wb_sel <= wb_alu;
			d_fwd_a <= 1'b0;
			d_fwd_b <= 1'b0;
		end else if (branch_taken || !instr_valid || !op_ok) begin
			d_valid <= 1'b0; // Bubble
			d_flag_write <= 1'b0;
			d_is_beq <= 1'b0;
			d_is_bne <= 1'b0;
			d_is_jal <= 1'b0;
			d_fwd_a <= 1'b0;
			d_fwd_b <= 1'b0;
		end else begin
			d_valid <= 1'b1;
			d_alu_funct <= funct;
			d_use_imm <= use_imm;
			d_dst <= dst;
			d_flag_write <= flag_write;
			d_is_beq <= is_beq;
			d_is_bne <= is_bne;
			d_is_jal <= is_jal;
			d_wb_sel <= wb_sel;
			d_fwd_a <= fwd_a;
			d_fwd_b <= fwd_b;
		end
	end

	// Payload half, qualified by d_valid
	always_ff @(posedge clk) begin
		d_rs_data <= rs_data;
		d_rt_data <= rt_data;
		d_imm <= imm;
		d_next_pc <= pc + pc_width'(1);
	end

endmodule

// ==== exec_core.sv ====
// Three-stage core with no fetch, no memory and no stalls, so one instruction is accepted every cycle
module exec_core #(
	parameter int data_width = core_pkg::data_width_def,
	parameter int pc_width = core_pkg::pc_width_def
) (
	input logic clk,
	input logic rst,
	input logic [31:0] instr,
	input logic instr_valid,
	input logic [pc_width-1:0] pc,
	output logic wb_en,
	output core_pkg::reg_addr_t wb_addr,
	output logic [data_width-1:0] wb_data,
	output logic branch_taken,
	output logic [pc_width-1:0] branch_target,
	output core_pkg::flags_t flags
);
	import core_pkg::*;
	import ctrl_pkg::*;

	// Decode to execute
	logic d_valid;
	alu_funct_t d_alu_funct;
	logic d_use_imm;
	reg_addr_t d_dst;
	logic d_flag_write;
	logic d_is_beq;
	logic d_is_bne;
	logic d_is_jal;
	wb_sel_t d_wb_sel;
	logic [data_width-1:0] d_rs_data;
	logic [data_width-1:0] d_rt_data;
	logic [data_width-1:0] d_imm;
	logic [pc_width-1:0] d_next_pc;
	logic d_fwd_a;
	logic d_fwd_b;

	// Execute to result
	logic x_valid;
	reg_addr_t x_dst;
	wb_sel_t x_wb_sel;
	logic x_is_beq;
	logic x_is_bne;
	logic x_is_jal;
	logic [data_width-1:0] x_alu_res;
	logic x_zero;
	logic [pc_width-1:0] x_next_pc;
	logic [pc_width-1:0] x_target;

	decode_stage #(
		.data_width(data_width),
		.pc_width(pc_width)
	) u_decode (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instr_valid(instr_valid),
		.pc(pc),
		.branch_taken(branch_taken),
		.wb_en(wb_en), // Register write and write-through
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.d_valid(d_valid),
		.d_alu_funct(d_alu_funct),
		.d_use_imm(d_use_imm),
		.d_dst(d_dst),
		.d_flag_write(d_flag_write),
		.d_is_beq(d_is_beq),
		.d_is_bne(d_is_bne),
		.d_is_jal(d_is_jal),
		.d_wb_sel(d_wb_sel),
		.d_rs_data(d_rs_data),
		.d_rt_data(d_rt_data),
		.d_imm(d_imm),
		.d_next_pc(d_next_pc),
		.d_fwd_a(d_fwd_a),
		.d_fwd_b(d_fwd_b)
	);

	execute_stage #(
		.data_width(data_width),
		.pc_width(pc_width)
	) u_execute (
		.clk(clk),
		.rst(rst),
		.branch_taken(branch_taken),
		.d_valid(d_valid),
		.d_alu_funct(d_alu_funct),
		.d_use_imm(d_use_imm),
		.d_dst(d_dst),
		.d_flag_write(d_flag_write),
		.d_is_beq(d_is_beq),
		.d_is_bne(d_is_bne),
		.d_is_jal(d_is_jal),
		.d_wb_sel(d_wb_sel),
		.d_rs_data(d_rs_data),
		.d_rt_data(d_rt_data),
		.d_imm(d_imm),
		.d_next_pc(d_next_pc),
		.d_fwd_a(d_fwd_a),
		.d_fwd_b(d_fwd_b),
		.fwd_data(wb_data), // Forwarding source
		.x_valid(x_valid),
		.x_dst(x_dst),
		.x_wb_sel(x_wb_sel),
		.x_is_beq(x_is_beq),
		.x_is_bne(x_is_bne),
		.x_is_jal(x_is_jal),
		.x_alu_res(x_alu_res),
		.x_zero(x_zero),
		.x_next_pc(x_next_pc),
		.x_target(x_target),
		.flags(flags)
	);

	result_stage #(
		.data_width(data_width),
		.pc_width(pc_width)
	) u_result (
		.x_valid(x_valid),
		.x_dst(x_dst),
		.x_wb_sel(x_wb_sel),
		.x_is_beq(x_is_beq),
		.x_is_bne(x_is_bne),
		.x_is_jal(x_is_jal),
		.x_alu_res(x_alu_res),
		.x_zero(x_zero),
		.x_next_pc(x_next_pc),
		.x_target(x_target),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.branch_taken(branch_taken), // Squashes both younger stages
		.branch_target(branch_target)
	);

endmodule

// ==== exec_core_props.sv ====
// Sampled on the rising edge at the core's outputs; x_is_jal must be bound to the execute register bit
module exec_core_props (
	input logic clk,
	input logic rst,
	input logic wb_en,
	input core_pkg::reg_addr_t wb_addr,
	input logic branch_taken,
	input logic x_is_jal // Registered jal bit in front of the result stage
);
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	// Async reset keeps the result stage empty
	reset_quiet: assert property (@(posedge clk) rst |-> !wb_en && !branch_taken)
		else $error("wb_en or branch_taken high while rst is asserted");

	// Both younger slots are squashed after a taken branch
	flush_quiet: assert property (@(posedge clk) disable iff (rst)
		($past(branch_taken) || $past(branch_taken, 2)) |-> !wb_en)
		else $error("writeback within two cycles of a taken branch");

	// Link register written only through jal
	link_only_jal: assert property (@(posedge clk) disable iff (rst)
		(wb_en && wb_addr == link_reg) |-> x_is_jal)
		else $error("link register written by an instruction other than jal");

endmodule

// ==== exec_core_tb.sv ====
// Random 400-slot program checked each cycle against an in-order model; only jal targets r15
module exec_core_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;
	import ctrl_pkg::*;

	localparam int data_width = data_width_def;
	localparam int pc_width = pc_width_def;
	localparam int msb = data_width - 1;
	localparam int n_slots = 400;
	localparam int reset_limit = 20; // Cycles
	localparam int drain_limit = 10;

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic instr_valid;
	logic [pc_width-1:0] pc;
	logic wb_en;
	reg_addr_t wb_addr;
	logic [data_width-1:0] wb_data;
	logic branch_taken;
	logic [pc_width-1:0] branch_target;
	flags_t flags;

	logic [31:0] lfsr;
	logic [data_width-1:0] mregs [reg_count]; // Model register file
	flags_t mflags;
	int squash_left; // Slots still dropped behind a taken branch
	int redirect_slot; // Fetch resumes at the target here
	logic [pc_width-1:0] redirect_pc;
	logic [pc_width-1:0] fetch_pc;

	// Expected result stage view per issue slot
	logic exp_wb_en [n_slots];
	reg_addr_t exp_wb_addr [n_slots];
	logic [data_width-1:0] exp_wb_data [n_slots];
	logic exp_taken [n_slots];
	logic [pc_width-1:0] exp_target [n_slots];
	flags_t exp_flags [n_slots];

	int wb_errors;
	int flag_errors;
	int branch_errors;
	int other_errors;
	int n_wb;
	int n_taken;

	tb_clock #(.half_period(10)) u_clock (.clk(clk), .rst(rst));

	exec_core #(
		.data_width(data_width),
		.pc_width(pc_width)
	) dut (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instr_valid(instr_valid),
		.pc(pc),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.flags(flags)
	);

	bind exec_core exec_core_props u_props (
		.clk(clk),
		.rst(rst),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.branch_taken(branch_taken),
		.x_is_jal(x_is_jal)
	);

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// Mostly ALU ops with a few compares and jumps
	function automatic opcode_t pick_op();
		logic [31:0] v;
		v = take_bits(5);
		if (v < 5) return op_add;
		if (v < 8) return op_sub;
		if (v < 10) return op_and;
		if (v < 12) return op_or;
		if (v < 14) return op_xor;
		if (v < 16) return op_slt;
		if (v < 18) return op_shl;
		if (v < 20) return op_shr;
		if (v < 27) return op_addi;
		if (v < 29) return op_beq;
		if (v < 30) return op_bne;
		if (v < 31) return op_jal;
		return op_nop;
	endfunction

	// Sources from r0..r3 to force reuse and r15 now and then
	function automatic reg_addr_t pick_src();
		logic [31:0] v;
		v = take_bits(3);
		return (v[2:0] == 3'd7) ? link_reg : {2'b00, v[1:0]};
	endfunction

	function automatic reg_addr_t pick_dst();
		logic [31:0] v;
		v = take_bits(2);
		return {2'b00, v[1:0]};
	endfunction

	function automatic void set_flags(input logic c, input logic v,
		input logic [data_width-1:0] r);
		mflags.carry = c;
		mflags.overflow = v;
		mflags.negative = r[msb];
		mflags.zero = (r == '0);
	endfunction

	// Drive one slot and run it through the model
	task automatic issue_slot(input int s);
		opcode_t op;
		reg_addr_t rd;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dst;
		logic [31:0] v;
		logic [imm_width-1:0] imm_bits;
		logic [data_width-1:0] imm;
		logic [data_width-1:0] a;
		logic [data_width-1:0] b;
		logic [data_width-1:0] res;
		logic [data_width:0] wide;
		logic [pc_width-1:0] next_pc;
		logic [pc_width-1:0] target;
		logic valid;
		logic writes;
		logic taken;
		v = take_bits(3);
		valid = (v != 0); // About one slot in eight empty
		op = pick_op();
		rs = pick_src();
		rd = pick_dst();
		rt = (op == op_addi) ? pick_dst() : pick_src(); // addi writes rt
		v = take_bits(imm_width);
		imm_bits = v[imm_width-1:0];
		if (s == redirect_slot) fetch_pc = redirect_pc;
		instr = {op, rd, rs, rt, imm_bits};
		instr_valid = valid;
		pc = fetch_pc;
		fetch_pc = fetch_pc + pc_width'(1);

		imm = {{(data_width-imm_width){imm_bits[imm_width-1]}}, imm_bits};
		next_pc = pc + pc_width'(1);
		target = next_pc + imm[pc_width-1:0]; // Wraps at pc_width
		a = mregs[rs];
		b = mregs[rt];
		res = '0;
		dst = rd;
		writes = 1'b1;
		taken = 1'b0;
		exp_wb_en[s] = 1'b0;
		exp_wb_addr[s] = '0;
		exp_wb_data[s] = '0;
		exp_taken[s] = 1'b0;
		exp_target[s] = target;
		if (squash_left > 0) begin
			squash_left--; // Dropped behind a branch
		end else if (valid && op != op_nop) begin
			case (op)
				op_add: begin
					res = a + b;
					wide = {a[msb], a} + {b[msb], b}; // Signed sum one bit wider
					set_flags(res < a, wide[data_width] != wide[msb], res); // Carry on wrap
				end
				op_addi: begin
					dst = rt;
					res = a + imm;
					wide = {a[msb], a} + {imm[msb], imm};
					set_flags(res < a, wide[data_width] != wide[msb], res);
				end
				op_sub, op_beq, op_bne: begin
					res = a - b;
					wide = {a[msb], a} - {b[msb], b};
					set_flags(a < b, wide[data_width] != wide[msb], res); // Borrow
					if (op != op_sub) begin
						writes = 1'b0;
						taken = (op == op_beq) ? (a == b) : (a != b);
					end
				end
				op_and: res = a & b;
				op_or: res = a | b;
				op_xor: res = a ^ b;
				op_slt: begin
					res[0] = $signed(a) < $signed(b);
					set_flags(1'b0, 1'b0, res);
				end
				op_shl: res = a << b[4:0];
				op_shr: res = a >> b[4:0];
				op_jal: begin
					dst = link_reg;
					res[pc_width-1:0] = next_pc; // Link value zero-extended
					taken = 1'b1;
				end
				default: writes = 1'b0;
			endcase
			if (writes) begin
				mregs[dst] = res;
				exp_wb_en[s] = 1'b1;
				exp_wb_addr[s] = dst;
				exp_wb_data[s] = res;
			end
			if (taken) begin
				exp_taken[s] = 1'b1;
				squash_left = 2;
				redirect_slot = s + 3; // First fetch from the target
				redirect_pc = target;
				n_taken++;
			end
		end
		exp_flags[s] = mflags;
	endtask

	task automatic check_wb(input logic exp_en, input reg_addr_t exp_addr,
		input logic [data_width-1:0] exp_data);
		if (wb_en !== exp_en) begin
			$display("Mismatch at %0t: wb_en expected %b got %b", $time, exp_en, wb_en);
			wb_errors++;
		end else if (exp_en) begin
			n_wb++;
			if (wb_addr !== exp_addr) begin
				$display("Mismatch at %0t: wb_addr expected %0d got %0d",
					$time, exp_addr, wb_addr);
				wb_errors++;
			end
			if (wb_data !== exp_data) begin
				$display("Mismatch at %0t: wb_data expected %h got %h",
					$time, exp_data, wb_data);
				wb_errors++;
			end
		end
	endtask

	task automatic check_flags(input flags_t exp);
		if (flags !== exp) begin
			$display("Mismatch at %0t: flags (cvnz) expected %b got %b", $time, exp, flags);
			flag_errors++;
		end
	endtask

	task automatic check_branch(input logic exp_taken_bit, input logic [pc_width-1:0] exp_tgt);
		if (branch_taken !== exp_taken_bit) begin
			$display("Mismatch at %0t: branch_taken expected %b got %b",
				$time, exp_taken_bit, branch_taken);
			branch_errors++;
		end else if (exp_taken_bit && branch_target !== exp_tgt) begin
			$display("Mismatch at %0t: branch_target expected %h got %h",
				$time, exp_tgt, branch_target);
			branch_errors++;
		end
	endtask

	initial begin
		int wait_cnt;
		int idle_cnt;
		int drain_cnt;
		lfsr = 32'hbd252def;
		instr = '0;
		instr_valid = 1'b0;
		pc = '0;
		for (int i = 0; i < reg_count; i++) begin
			mregs[i] = '0;
		end
		mflags = '0;
		squash_left = 0;
		redirect_slot = -1;
		redirect_pc = '0;
		fetch_pc = '0;
		wb_errors = 0;
		flag_errors = 0;
		branch_errors = 0;
		other_errors = 0;
		n_wb = 0;
		n_taken = 0;

		// Outputs held quiet by the async reset
		wait_cnt = 0;
		@(posedge clk);
		while (rst && wait_cnt < reset_limit) begin
			if (wb_en !== 1'b0 || branch_taken !== 1'b0 || flags !== '0) begin
				$display("Error at %0t: outputs not quiet during reset", $time);
				other_errors++;
			end
			wait_cnt++;
			@(posedge clk);
		end

		if (rst) begin
			$display("Error at %0t: reset still asserted after %0d cycles", $time, reset_limit);
			other_errors++;
		end else begin
			// Slot c issued at this falling edge while slot c-2 shows at the outputs
			for (int c = 0; c < n_slots + 2; c++) begin
				@(negedge clk);
				if (c >= 2) begin
					check_wb(exp_wb_en[c-2], exp_wb_addr[c-2], exp_wb_data[c-2]);
					check_branch(exp_taken[c-2], exp_target[c-2]);
					check_flags(exp_flags[c-2]);
				end else begin
					check_wb(1'b0, '0, '0); // Nothing completed yet
					check_branch(1'b0, '0);
					check_flags('0);
				end
				if (c < n_slots) begin
					issue_slot(c);
				end else begin
					instr = '0;
					instr_valid = 1'b0;
				end
			end

			// Pipeline should empty and stay empty
			idle_cnt = 0;
			drain_cnt = 0;
			while (idle_cnt < 3 && drain_cnt < drain_limit) begin
				@(negedge clk);
				drain_cnt++;
				if (wb_en !== 1'b0 || branch_taken !== 1'b0) idle_cnt = 0;
				else idle_cnt++;
			end
			if (idle_cnt < 3) begin
				$display("Error at %0t: pipeline did not drain within %0d cycles",
					$time, drain_limit);
				other_errors++;
			end
			check_flags(mflags);
		end

		$display("Writebacks %0d, taken branches %0d; errors wb %0d flags %0d branch %0d other %0d",
			n_wb, n_taken, wb_errors, flag_errors, branch_errors, other_errors);
		if (wb_errors + flag_errors + branch_errors + other_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== execute_stage.sv ====
// Flags load only for valid flag-writing instructions and keep their value through a squash
module execute_stage #(
	parameter int data_width = core_pkg::data_width_def,
	parameter int pc_width = core_pkg::pc_width_def
) (
	input logic clk,
	input logic rst,
	input logic branch_taken, // Squash, loads a bubble
	input logic d_valid,
	input ctrl_pkg::alu_funct_t d_alu_funct,
	input logic d_use_imm,
	input core_pkg::reg_addr_t d_dst,
	input logic d_flag_write,
	input logic d_is_beq,
	input logic d_is_bne,
	input logic d_is_jal,
	input ctrl_pkg::wb_sel_t d_wb_sel,
	input logic [data_width-1:0] d_rs_data,
	input logic [data_width-1:0] d_rt_data,
	input logic [data_width-1:0] d_imm,
	input logic [pc_width-1:0] d_next_pc,
	input logic d_fwd_a,
	input logic d_fwd_b,
	input logic [data_width-1:0] fwd_data, // Writeback value of the older instruction
	output logic x_valid,
	output core_pkg::reg_addr_t x_dst,
	output ctrl_pkg::wb_sel_t x_wb_sel,
	output logic x_is_beq,
	output logic x_is_bne,
	output logic x_is_jal,
	output logic [data_width-1:0] x_alu_res,
	output logic x_zero,
	output logic [pc_width-1:0] x_next_pc,
	output logic [pc_width-1:0] x_target,
	output core_pkg::flags_t flags
);
	import core_pkg::*;
	import ctrl_pkg::*;

	logic [data_width-1:0] op_a;
	logic [data_width-1:0] op_b;
	logic [data_width-1:0] alu_res;
	logic [pc_width-1:0] target;
	flags_t alu_flags;

	// Operand muxes
	assign op_a = d_fwd_a ? fwd_data : d_rs_data;
	assign op_b = d_use_imm ? d_imm :
		d_fwd_b ? fwd_data : d_rt_data; // Immediate wins over forwarding

	alu #(
		.data_width(data_width)
	) u_alu (
		.op_a(op_a),
		.op_b(op_b),
		.funct(d_alu_funct),
		.res(alu_res),
		.flags_out(alu_flags)
	);

	// pc+1 plus immediate, wraps at pc_width
	assign target = d_next_pc + d_imm[pc_width-1:0];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			flags <= '0;
		end else if (d_valid && d_flag_write && !branch_taken) begin
			flags <= alu_flags;
		end
	end

	// Control half of the execute/result register
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			x_valid <= 1'b0;
			x_dst <= '0;
			x_wb_sel <= wb_alu;
			x_is_beq <= 1'b0;
			x_is_bne <= 1'b0;
			x_is_jal <= 1'b0;
		end else if (branch_taken || !d_valid) begin
			x_valid <= 1'b0;
			x_is_beq <= 1'b0;
			x_is_bne <= 1'b0;
			x_is_jal <= 1'b0;
		end else begin
			x_valid <= 1'b1;
			x_dst <= d_dst;
			x_wb_sel <= d_wb_sel;
			x_is_beq <= d_is_beq;
			x_is_bne <= d_is_bne;
			x_is_jal <= d_is_jal;
		end
	end

	// Payload half
	always_ff @(posedge clk) begin
		x_alu_res <= alu_res;
		x_zero <= alu_flags.zero; // Compare result for beq and bne
		x_next_pc <= d_next_pc;
		x_target <= target;
	end

endmodule

// ==== flist.f ====
core_pkg.sv
ctrl_pkg.sv
alu.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
exec_core.sv
tb_clock.sv
exec_core_props.sv
exec_core_tb.sv

// ==== result_stage.sv ====
// Writeback and branch outputs are combinational from the execute register and need data_width >= pc_width
module result_stage #(
	parameter int data_width = core_pkg::data_width_def,
	parameter int pc_width = core_pkg::pc_width_def
) (
	input logic x_valid,
	input core_pkg::reg_addr_t x_dst,
	input ctrl_pkg::wb_sel_t x_wb_sel,
	input logic x_is_beq,
	input logic x_is_bne,
	input logic x_is_jal,
	input logic [data_width-1:0] x_alu_res,
	input logic x_zero,
	input logic [pc_width-1:0] x_next_pc,
	input logic [pc_width-1:0] x_target,
	output logic wb_en,
	output core_pkg::reg_addr_t wb_addr,
	output logic [data_width-1:0] wb_data,
	output logic branch_taken,
	output logic [pc_width-1:0] branch_target
);
	import ctrl_pkg::*;

	logic beq_hit;
	logic bne_hit;

	// Everything but the compares writes a register
	assign wb_en = x_valid && !x_is_beq && !x_is_bne;
	assign wb_addr = x_dst;

	// jal links pc+1
	assign wb_data = (x_wb_sel == wb_pc) ? data_width'(x_next_pc) : x_alu_res;

	// Branch resolution
	assign beq_hit = x_is_beq && x_zero;
	assign bne_hit = x_is_bne && !x_zero;
	assign branch_taken = x_valid && (x_is_jal || beq_hit || bne_hit);
	assign branch_target = x_target; // Computed one stage earlier

endmodule

// ==== tb_clock.sv ====
// Free-running clock of twice half_period, reset held high over the first two rising edges
module tb_clock #(
	parameter int half_period = 10
) (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk; // 20 ns period by default
	end

	// Released on a falling edge, away from the sampling edge
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule
